//--- decode_stage.f
rv_decode_pkg.sv
credit_fifo.sv
inst_decoder.sv
decode_stage_top.sv
decode_stage_assertions.sv
tb_decode_stage.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_decode_stage
FILELIST = decode_stage.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = Result: PASSED

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

.PHONY: all build run lint clean

//--- tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

  localparam int IN_DEPTH       = 4;
  localparam int OUT_DEPTH      = 4;
  localparam int OUT_CREDITS    = 4;
  localparam int NUM_INSTR      = 400;
  localparam int CLK_PERIOD     = 100;
  // slow downstream phases average about eight cycles per op
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 40;

  logic        clock;
  logic        reset;
  logic        in_valid;
  logic [31:0] in_pc;
  logic [31:0] in_word;
  logic        op_credit;
  logic        in_credit;
  logic        op_valid;
  logic [31:0] op_pc;
  logic [2:0]  op_class;
  logic [3:0]  op_alu;
  logic [4:0]  op_rs1;
  logic [4:0]  op_rs2;
  logic [4:0]  op_rd;
  logic        op_rd_wen;
  logic [31:0] op_imm;
  logic [1:0]  op_mem_size;
  logic        op_mem_unsigned;
  logic        op_load_use;

  rv_decode_pkg::decoded_op_t expected_q[$];
  logic [15:0] lfsr_state;
  logic [31:0] next_pc;
  logic [4:0]  prev_rd;
  logic        prev_load;
  int          up_credits;
  int          ds_credits;
  int          pending_returns;
  int          sent;
  int          received;
  int          in_credit_pulses;
  int          mismatch_count;
  int          failure_count;

  decode_stage_top #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_DEPTH   (OUT_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_decode_stage_top (.*);

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // value holds the raw immediate in its low bits
  function automatic logic [31:0] sign_extend(input logic [31:0] value, input int bits);
    return $signed(value << (32 - bits)) >>> (32 - bits);
  endfunction

  // reference decode straight from the rv32i encoding tables
  function automatic rv_decode_pkg::decoded_op_t ref_decode(input logic [31:0] pc,
      input logic [31:0] word, input logic [4:0] last_rd, input logic last_load);
    rv_decode_pkg::decoded_op_t op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       is_reg;
    logic       legal;
    logic       alt;
    logic       use1;
    logic       use2;
    f3 = word[14:12];
    f7 = word[31:25];
    is_reg = (word[6:0] == rv_decode_pkg::OPC_OP);
    use1 = 1'b0;
    use2 = 1'b0;
    op = '0;
    op.pc = pc;
    op.op_class = rv_decode_pkg::CLASS_ILLEGAL;
    op.alu_op = rv_decode_pkg::ALU_ADD;
    op.rs1 = word[19:15];
    op.rs2 = word[24:20];
    op.rd = word[11:7];
    case (word[6:0])
      rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC: begin
        op.op_class = rv_decode_pkg::CLASS_UPPER;
        op.imm = {word[31:12], 12'h000};
        if (word[6:0] == rv_decode_pkg::OPC_LUI) begin
          op.rs1 = 5'd0;
        end
      end
      rv_decode_pkg::OPC_JAL: begin
        op.op_class = rv_decode_pkg::CLASS_JUMP;
        op.imm = sign_extend({11'd0, word[31], word[19:12], word[20], word[30:21], 1'b0}, 21);
      end
      rv_decode_pkg::OPC_JALR: begin
        if (f3 == 3'b000) begin
          op.op_class = rv_decode_pkg::CLASS_JUMP;
          op.imm = sign_extend({20'd0, word[31:20]}, 12);
          use1 = 1'b1;
        end
      end
      rv_decode_pkg::OPC_BRANCH: begin
        if (f3 != 3'b010 && f3 != 3'b011) begin
          op.op_class = rv_decode_pkg::CLASS_BRANCH;
          op.imm = sign_extend({19'd0, word[31], word[7], word[30:25], word[11:8], 1'b0}, 13);
          case (f3)
            3'b000, 3'b001: op.alu_op = rv_decode_pkg::ALU_SUB;
            3'b100, 3'b101: op.alu_op = rv_decode_pkg::ALU_SLT;
            default:        op.alu_op = rv_decode_pkg::ALU_SLTU;
          endcase
          use1 = 1'b1;
          use2 = 1'b1;
        end
      end
      rv_decode_pkg::OPC_LOAD: begin
        if (f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          op.op_class = rv_decode_pkg::CLASS_LOAD;
          op.imm = sign_extend({20'd0, word[31:20]}, 12);
          op.mem_size = f3[1] ? 2'd2 : {1'b0, f3[0]};
          op.mem_unsigned = f3[2];
          use1 = 1'b1;
        end
      end
      rv_decode_pkg::OPC_STORE: begin
        if (f3 inside {3'b000, 3'b001, 3'b010}) begin
          op.op_class = rv_decode_pkg::CLASS_STORE;
          op.imm = sign_extend({20'd0, word[31:25], word[11:7]}, 12);
          op.mem_size = f3[1:0];
          use1 = 1'b1;
          use2 = 1'b1;
        end
      end
      rv_decode_pkg::OPC_OP_IMM, rv_decode_pkg::OPC_OP: begin
        if (is_reg) begin
          legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
          alt = (f7 == 7'h20);
        end else begin
          legal = (f3 != 3'b001 || f7 == 7'h00) &&
                  (f3 != 3'b101 || f7 == 7'h00 || f7 == 7'h20);
          alt = (f3 == 3'b101 && f7 == 7'h20);
        end
        if (legal) begin
          op.op_class = rv_decode_pkg::CLASS_ALU;
          op.imm = is_reg ? 32'd0 : sign_extend({20'd0, word[31:20]}, 12);
          case (f3)
            3'b000:  op.alu_op = alt ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
            3'b001:  op.alu_op = rv_decode_pkg::ALU_SLL;
            3'b010:  op.alu_op = rv_decode_pkg::ALU_SLT;
            3'b011:  op.alu_op = rv_decode_pkg::ALU_SLTU;
            3'b100:  op.alu_op = rv_decode_pkg::ALU_XOR;
            3'b101:  op.alu_op = alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
            3'b110:  op.alu_op = rv_decode_pkg::ALU_OR;
            default: op.alu_op = rv_decode_pkg::ALU_AND;
          endcase
          use1 = 1'b1;
          use2 = is_reg;
        end
      end
      default: ;
    endcase
    op.rd_wen = (op.rd != 5'd0) && (op.op_class inside {rv_decode_pkg::CLASS_UPPER,
                rv_decode_pkg::CLASS_JUMP, rv_decode_pkg::CLASS_LOAD, rv_decode_pkg::CLASS_ALU});
    op.load_use = last_load && (last_rd != 5'd0) &&
                  ((use1 && op.rs1 == last_rd) || (use2 && op.rs2 == last_rd));
    return op;
  endfunction

  // mostly the nine opcodes, registers often drawn from x0..x7 to provoke hazards
  function automatic logic [31:0] make_word();
    logic [3:0] sel;
    logic [31:0] w;
    sel = 4'(take_bits(4));
    w = take_bits(32);
    case (sel)
      4'd0:                 w[6:0] = rv_decode_pkg::OPC_LUI;
      4'd1:                 w[6:0] = rv_decode_pkg::OPC_AUIPC;
      4'd2:                 w[6:0] = rv_decode_pkg::OPC_JAL;
      4'd3:                 w[6:0] = rv_decode_pkg::OPC_JALR;
      4'd4, 4'd5:           w[6:0] = rv_decode_pkg::OPC_BRANCH;
      4'd6, 4'd7:           w[6:0] = rv_decode_pkg::OPC_LOAD;
      4'd8:                 w[6:0] = rv_decode_pkg::OPC_STORE;
      4'd9, 4'd10, 4'd11:   w[6:0] = rv_decode_pkg::OPC_OP_IMM;
      4'd12, 4'd13:         w[6:0] = rv_decode_pkg::OPC_OP;
      default:              return w;
    endcase
    if (take_bits(1) != 0) begin
      w[11:7] = {2'b00, 3'(take_bits(3))};
    end
    if (take_bits(1) != 0) begin
      w[19:15] = {2'b00, 3'(take_bits(3))};
    end
    if (take_bits(1) != 0) begin
      w[24:20] = {2'b00, 3'(take_bits(3))};
    end
    if ((w[6:0] == rv_decode_pkg::OPC_OP || w[6:0] == rv_decode_pkg::OPC_OP_IMM) &&
        take_bits(2) != 0) begin
      w[31:25] = (take_bits(1) != 0) ? 7'h20 : 7'h00;
    end
    if (w[6:0] == rv_decode_pkg::OPC_JALR && take_bits(1) != 0) begin
      w[14:12] = 3'b000;
    end
    return w;
  endfunction

  task automatic log_mismatch(input string test, input logic [31:0] pc,
                              input logic [63:0] expected, input logic [63:0] actual);
    mismatch_count++;
    $display("Mismatch %s at pc %h: expected %h, actual %h", test, pc, expected, actual);
  endtask

  task automatic compare_op(input rv_decode_pkg::decoded_op_t exp,
                            input rv_decode_pkg::decoded_op_t act);
    assert (act.pc === exp.pc) else
      log_mismatch("order", exp.pc, 64'(exp.pc), 64'(act.pc));
    if (exp.op_class == rv_decode_pkg::CLASS_ILLEGAL) begin
      assert (act.op_class === exp.op_class && act.rd_wen === 1'b0) else
        log_mismatch("illegal_encoding", exp.pc, 64'({exp.op_class, exp.rd_wen}),
                     64'({act.op_class, act.rd_wen}));
    end
    assert ({act.op_class, act.alu_op, act.rs1, act.rs2, act.rd, act.rd_wen} ===
            {exp.op_class, exp.alu_op, exp.rs1, exp.rs2, exp.rd, exp.rd_wen}) else
      log_mismatch("field_decode", exp.pc,
                   64'({exp.op_class, exp.alu_op, exp.rs1, exp.rs2, exp.rd, exp.rd_wen}),
                   64'({act.op_class, act.alu_op, act.rs1, act.rs2, act.rd, act.rd_wen}));
    assert ({act.imm, act.mem_size, act.mem_unsigned} ===
            {exp.imm, exp.mem_size, exp.mem_unsigned}) else
      log_mismatch("immediate", exp.pc, 64'({exp.imm, exp.mem_size, exp.mem_unsigned}),
                   64'({act.imm, act.mem_size, act.mem_unsigned}));
    assert (act.load_use === exp.load_use) else
      log_mismatch("load_use", exp.pc, 64'(exp.load_use), 64'(act.load_use));
  endtask

  // sampled mid-cycle, so every value here is what the DUT drives this cycle
  task automatic observe_outputs();
    rv_decode_pkg::decoded_op_t actual;
    if (in_credit) begin
      up_credits++;
      in_credit_pulses++;
      assert (up_credits <= IN_DEPTH) else begin
        failure_count++;
        $display("in_credit returned more credits than upstream ever spent");
      end
    end
    if (op_valid) begin
      actual = {op_pc, op_class, op_alu, op_rs1, op_rs2, op_rd, op_rd_wen, op_imm,
                op_mem_size, op_mem_unsigned, op_load_use};
      assert (ds_credits > 0) else begin
        failure_count++;
        $display("op_valid was raised while the downstream had no free slot");
      end
      ds_credits--;
      received++;
      pending_returns++;
      if (expected_q.size() == 0) begin
        failure_count++;
        $display("an operation came out that was never sent");
      end else begin
        compare_op(expected_q.pop_front(), actual);
      end
    end
    if (op_credit) begin
      ds_credits++;
    end
  endtask

  task automatic drive_inputs();
    rv_decode_pkg::decoded_op_t exp;
    logic [31:0] word;
    logic        slow;
    if (sent < NUM_INSTR && up_credits > 0 && take_bits(2) != 0) begin
      word = make_word();
      exp = ref_decode(next_pc, word, prev_rd, prev_load);
      expected_q.push_back(exp);
      prev_rd = exp.rd;
      prev_load = (exp.op_class == rv_decode_pkg::CLASS_LOAD);
      in_valid <= 1'b1;
      in_pc <= next_pc;
      in_word <= word;
      next_pc = next_pc + 32'd4;
      sent++;
      up_credits--;
    end else begin
      in_valid <= 1'b0;
    end
    // alternate fast and slow downstream phases to back the pipeline up
    slow = ((received / 64) % 2) == 1;
    if (pending_returns > 0 && take_bits(slow ? 3 : 1) == 0) begin
      op_credit <= 1'b1;
      pending_returns--;
    end else begin
      op_credit <= 1'b0;
    end
  endtask

  initial begin
    lfsr_state = 16'd27;
    next_pc = 32'h0000_1000;
    prev_rd = 5'd0;
    prev_load = 1'b0;
    up_credits = IN_DEPTH;
    ds_credits = OUT_CREDITS;
    pending_returns = 0;
    sent = 0;
    received = 0;
    in_credit_pulses = 0;
    mismatch_count = 0;
    failure_count = 0;
    reset = 1'b1;
    in_valid = 1'b0;
    in_pc = '0;
    in_word = '0;
    op_credit = 1'b0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    while (received < NUM_INSTR) begin
      @(negedge clock);
      observe_outputs();
      @(posedge clock);
      drive_inputs();
    end
    // a few idle cycles to catch stray outputs after the drain
    repeat (8) begin
      @(negedge clock);
      observe_outputs();
      @(posedge clock);
      drive_inputs();
    end
    assert (in_credit_pulses == NUM_INSTR) else begin
      failure_count++;
      $display("in_credit pulsed %0d times for %0d accepted instructions",
               in_credit_pulses, NUM_INSTR);
    end
    $display("checked %0d of %0d operations: %0d mismatches, %0d other errors",
             received, NUM_INSTR, mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES + 20) @(posedge clock);
    $display("watchdog timeout: %0d of %0d operations came out", received, NUM_INSTR);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- decode_stage_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_assertions #(
  parameter int DEPTH        = 4,
  parameter int INIT_CREDITS = 4
) (
  input wire                                clock,
  input wire                                reset,
  input wire                                wr_valid,
  input wire                                credit_in,
  input wire                                rd_valid,
  input wire                                credit_out,
  input wire [$clog2(DEPTH + 1)-1:0]        count,
  input wire [$clog2(INIT_CREDITS + 1)-1:0] credits
);

  int credits_seen;

  // credits granted by the receiver minus entries sent, counted at the ports
  always_ff @(posedge clock) begin
    if (reset) begin
      credits_seen <= INIT_CREDITS;
    end else begin
      credits_seen <= credits_seen + int'(credit_in) - int'(rd_valid);
    end
  end

  // every send spends a credit
  send_needs_credit: assert property (@(posedge clock) disable iff (reset)
    rd_valid |-> credits_seen > 0)
    else $error("credit_fifo sent an entry with no credit left");

  // the writer only sends while it holds a credit for a free slot
  no_overflow: assert property (@(posedge clock) disable iff (reset)
    wr_valid |-> int'(count) < DEPTH)
    else $error("credit_fifo written while full");

  credits_bounded: assert property (@(posedge clock) disable iff (reset)
    int'(credits) <= INIT_CREDITS)
    else $error("credit_fifo holds more credits than it started with");

  quiet_after_reset: assert property (@(posedge clock)
    reset |=> !credit_out)
    else $error("credit_fifo returned a credit right after reset");

endmodule

bind credit_fifo decode_stage_assertions #(
  .DEPTH        (DEPTH),
  .INIT_CREDITS (INIT_CREDITS)
) u_fifo_assertions (
  .clock      (clock),
  .reset      (reset),
  .wr_valid   (wr_valid),
  .credit_in  (credit_in),
  .rd_valid   (rd_valid),
  .credit_out (credit_out),
  .count      (count),
  .credits    (credits)
);

`default_nettype wire

//--- decode_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_top #(
  parameter int IN_DEPTH    = 4,
  parameter int OUT_DEPTH   = 4,
  parameter int OUT_CREDITS = 4
) (
  input  wire         clock,
  input  wire         reset,
  input  wire         in_valid,
  input  wire  [31:0] in_pc,
  input  wire  [31:0] in_word,
  input  wire         op_credit,
  output logic        in_credit,
  output logic        op_valid,
  output logic [31:0] op_pc,
  output logic [2:0]  op_class,
  output logic [3:0]  op_alu,
  output logic [4:0]  op_rs1,
  output logic [4:0]  op_rs2,
  output logic [4:0]  op_rd,
  output logic        op_rd_wen,
  output logic [31:0] op_imm,
  output logic [1:0]  op_mem_size,
  output logic        op_mem_unsigned,
  output logic        op_load_use
);

  // decoder holds one op per pipeline stage
  localparam int DEC_SLOTS = 2;

  rv_decode_pkg::fetch_entry_t in_entry;
  rv_decode_pkg::fetch_entry_t q_entry;
  rv_decode_pkg::decoded_op_t  d_op;
  rv_decode_pkg::decoded_op_t  out_op;
  logic q_valid;
  logic q_credit;
  logic d_valid;
  logic d_credit;

  assign in_entry.pc   = in_pc;
  assign in_entry.word = in_word;

  credit_fifo #(
    .DEPTH        (IN_DEPTH),
    .INIT_CREDITS (DEC_SLOTS),
    .payload_t    (rv_decode_pkg::fetch_entry_t)
  ) u_inst_queue (
    .clock      (clock),
    .reset      (reset),
    .wr_valid   (in_valid),
    .wr_data    (in_entry),
    .credit_in  (q_credit),
    .credit_out (in_credit),
    .rd_valid   (q_valid),
    .rd_data    (q_entry)
  );

  inst_decoder #(
    .OUT_DEPTH (OUT_DEPTH)
  ) u_decoder (
    .clock      (clock),
    .reset      (reset),
    .in_valid   (q_valid),
    .in_entry   (q_entry),
    .out_credit (d_credit),
    .in_credit  (q_credit),
    .out_valid  (d_valid),
    .out_op     (d_op)
  );

  credit_fifo #(
    .DEPTH        (OUT_DEPTH),
    .INIT_CREDITS (OUT_CREDITS),
    .payload_t    (rv_decode_pkg::decoded_op_t)
  ) u_op_queue (
    .clock      (clock),
    .reset      (reset),
    .wr_valid   (d_valid),
    .wr_data    (d_op),
    .credit_in  (op_credit),
    .credit_out (d_credit),
    .rd_valid   (op_valid),
    .rd_data    (out_op)
  );

  // flatten the decoded op for the execute stage
  assign op_pc           = out_op.pc;
  assign op_class        = out_op.op_class;
  assign op_alu          = out_op.alu_op;
  assign op_rs1          = out_op.rs1;
  assign op_rs2          = out_op.rs2;
  assign op_rd           = out_op.rd;
  assign op_rd_wen       = out_op.rd_wen;
  assign op_imm          = out_op.imm;
  assign op_mem_size     = out_op.mem_size;
  assign op_mem_unsigned = out_op.mem_unsigned;
  assign op_load_use     = out_op.load_use;

endmodule

`default_nettype wire

//--- inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder #(
  parameter int OUT_DEPTH = 4
) (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        in_valid,
  input  rv_decode_pkg::fetch_entry_t in_entry,
  input  wire                        out_credit,
  output logic                       in_credit,
  output logic                       out_valid,
  output rv_decode_pkg::decoded_op_t out_op
);

  localparam int CW = $clog2(OUT_DEPTH + 1);

  rv_decode_pkg::fetch_entry_t s1_entry;
  rv_decode_pkg::decoded_op_t  s2_op;
  rv_decode_pkg::decoded_op_t  dec;
  logic          s1_valid;
  logic          s2_valid;
  logic [CW-1:0] credits;
  logic          release_op;
  logic          advance;
  logic [4:0]    last_rd;
  logic          last_is_load;
  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic [31:0]   imm_i;
  logic [31:0]   imm_s;
  logic [31:0]   imm_b;
  logic [31:0]   imm_u;
  logic [31:0]   imm_j;
  logic          reads_rs1;
  logic          reads_rs2;

  function automatic rv_decode_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
      3'b001:  return rv_decode_pkg::ALU_SLL;
      3'b010:  return rv_decode_pkg::ALU_SLT;
      3'b011:  return rv_decode_pkg::ALU_SLTU;
      3'b100:  return rv_decode_pkg::ALU_XOR;
      3'b101:  return alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
      3'b110:  return rv_decode_pkg::ALU_OR;
      default: return rv_decode_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode = s1_entry.word[6:0];
  assign funct3 = s1_entry.word[14:12];
  assign funct7 = s1_entry.word[31:25];

  assign imm_i = {{20{s1_entry.word[31]}}, s1_entry.word[31:20]};
  assign imm_s = {{20{s1_entry.word[31]}}, s1_entry.word[31:25], s1_entry.word[11:7]};
  assign imm_b = {{20{s1_entry.word[31]}}, s1_entry.word[7], s1_entry.word[30:25],
                  s1_entry.word[11:8], 1'b0};
  assign imm_u = {s1_entry.word[31:12], 12'h000};
  assign imm_j = {{12{s1_entry.word[31]}}, s1_entry.word[19:12], s1_entry.word[20],
                  s1_entry.word[30:21], 1'b0};

  always_comb begin
    dec          = '0;
    dec.pc       = s1_entry.pc;
    dec.op_class = rv_decode_pkg::CLASS_ILLEGAL;
    dec.alu_op   = rv_decode_pkg::ALU_ADD;
    dec.rs1      = s1_entry.word[19:15];
    dec.rs2      = s1_entry.word[24:20];
    dec.rd       = s1_entry.word[11:7];
    reads_rs1    = 1'b0;
    reads_rs2    = 1'b0;

    case (opcode)
      rv_decode_pkg::OPC_LUI: begin
        // lui is x0 + imm
        dec.op_class = rv_decode_pkg::CLASS_UPPER;
        dec.rs1      = '0;
      end
      rv_decode_pkg::OPC_AUIPC: dec.op_class = rv_decode_pkg::CLASS_UPPER;
      rv_decode_pkg::OPC_JAL:   dec.op_class = rv_decode_pkg::CLASS_JUMP;
      rv_decode_pkg::OPC_JALR: begin
        if (funct3 == 3'b000) begin
          dec.op_class = rv_decode_pkg::CLASS_JUMP;
          reads_rs1    = 1'b1;
        end
      end
      rv_decode_pkg::OPC_BRANCH: begin
        // funct3 010 and 011 are unused
        if (funct3[2:1] != 2'b01) begin
          dec.op_class = rv_decode_pkg::CLASS_BRANCH;
          dec.alu_op   = !funct3[2] ? rv_decode_pkg::ALU_SUB :
                         (funct3[1] ? rv_decode_pkg::ALU_SLTU : rv_decode_pkg::ALU_SLT);
          reads_rs1    = 1'b1;
          reads_rs2    = 1'b1;
        end
      end
      rv_decode_pkg::OPC_LOAD: begin
        // lb lh lw lbu lhu
        if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
          dec.op_class     = rv_decode_pkg::CLASS_LOAD;
          dec.mem_size     = funct3[1:0];
          dec.mem_unsigned = funct3[2];
          reads_rs1        = 1'b1;
        end
      end
      rv_decode_pkg::OPC_STORE: begin
        if (!funct3[2] && funct3[1:0] != 2'b11) begin
          dec.op_class = rv_decode_pkg::CLASS_STORE;
          dec.mem_size = funct3[1:0];
          reads_rs1    = 1'b1;
          reads_rs2    = 1'b1;
        end
      end
      rv_decode_pkg::OPC_OP_IMM: begin
        // shift immediates carry funct7 in the top bits
        if ((funct3 != 3'b001 || funct7 == 7'h00) &&
            (funct3 != 3'b101 || funct7 == 7'h00 || funct7 == 7'h20)) begin
          dec.op_class = rv_decode_pkg::CLASS_ALU;
          dec.alu_op   = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
          reads_rs1    = 1'b1;
        end
      end
      rv_decode_pkg::OPC_OP: begin
        if (funct7 == 7'h00 ||
            (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          dec.op_class = rv_decode_pkg::CLASS_ALU;
          dec.alu_op   = alu_sel(funct3, funct7[5]);
          reads_rs1    = 1'b1;
          reads_rs2    = 1'b1;
        end
      end
      default: ;
    endcase

    case (dec.op_class)
      rv_decode_pkg::CLASS_UPPER:  dec.imm = imm_u;
      rv_decode_pkg::CLASS_JUMP:   dec.imm = (opcode == rv_decode_pkg::OPC_JAL) ? imm_j : imm_i;
      rv_decode_pkg::CLASS_BRANCH: dec.imm = imm_b;
      rv_decode_pkg::CLASS_LOAD:   dec.imm = imm_i;
      rv_decode_pkg::CLASS_STORE:  dec.imm = imm_s;
      rv_decode_pkg::CLASS_ALU:    dec.imm = (opcode == rv_decode_pkg::OPC_OP_IMM) ? imm_i : '0;
      default:                     dec.imm = '0;
    endcase

    dec.rd_wen = (dec.rd != 5'd0) &&
                 (dec.op_class == rv_decode_pkg::CLASS_UPPER ||
                  dec.op_class == rv_decode_pkg::CLASS_JUMP ||
                  dec.op_class == rv_decode_pkg::CLASS_LOAD ||
                  dec.op_class == rv_decode_pkg::CLASS_ALU);

    // previous op in program order is the last one moved into stage 2
    dec.load_use = last_is_load && (last_rd != 5'd0) &&
                   ((reads_rs1 && dec.rs1 == last_rd) || (reads_rs2 && dec.rs2 == last_rd));
  end

  assign release_op = s2_valid && (credits != '0);
  assign advance    = s1_valid && (!s2_valid || release_op);

  assign in_credit = release_op;
  assign out_valid = release_op;
  assign out_op    = s2_op;

  always_ff @(posedge clock) begin
    if (in_valid) begin
      s1_entry <= in_entry;
    end
    if (advance) begin
      s2_op   <= dec;
      last_rd <= dec.rd;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      s1_valid     <= 1'b0;
      s2_valid     <= 1'b0;
      last_is_load <= 1'b0;
      credits      <= CW'(OUT_DEPTH);
    end else begin
      // upstream holds only two credits, so a full stage 1 never sees in_valid
      if (in_valid) begin
        s1_valid <= 1'b1;
      end else if (advance) begin
        s1_valid <= 1'b0;
      end

      if (advance) begin
        s2_valid     <= 1'b1;
        last_is_load <= (dec.op_class == rv_decode_pkg::CLASS_LOAD);
      end else if (release_op) begin
        s2_valid <= 1'b0;
      end

      case ({out_credit, release_op})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
  parameter int  DEPTH        = 4,
  parameter int  INIT_CREDITS = 4,
  parameter type payload_t    = logic [31:0]
) (
  input  wire      clock,
  input  wire      reset,
  input  wire      wr_valid,
  input  payload_t wr_data,
  input  wire      credit_in,
  output logic     credit_out,
  output logic     rd_valid,
  output payload_t rd_data
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int NW = $clog2(DEPTH + 1);
  localparam int CW = $clog2(INIT_CREDITS + 1);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [NW-1:0] count;
  logic [CW-1:0] credits;
  logic          send;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // head leaves only while the receiver has room for it
  assign send       = (count != '0) && (credits != '0);
  assign rd_valid   = send;
  assign rd_data    = mem[rd_ptr];
  assign credit_out = send;

  always_ff @(posedge clock) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CW'(INIT_CREDITS);
    end else begin
      if (wr_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (send) begin
        rd_ptr <= next_ptr(rd_ptr);
      end

      case ({wr_valid, send})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // returned credit and a send in the same cycle cancel out
      case ({credit_in, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

  // rv32i major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  typedef enum logic [2:0] {
    CLASS_ALU,
    CLASS_BRANCH,
    CLASS_JUMP,
    CLASS_LOAD,
    CLASS_STORE,
    CLASS_UPPER,
    CLASS_ILLEGAL
  } op_class_e;

  // branches compare with sub, slt or sltu
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] word;
  } fetch_entry_t;

  // mem_size is 0 byte, 1 half, 2 word
  typedef struct packed {
    logic [31:0] pc;
    op_class_e   op_class;
    alu_op_e     alu_op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        rd_wen;
    logic [31:0] imm;
    logic [1:0]  mem_size;
    logic        mem_unsigned;
    logic        load_use;
  } decoded_op_t;

endpackage

`default_nettype wire
